// File: host_fifo_pkg.sv
// Host FIFO geometry package
// Chunk and cache-line shapes, ring indices and the record that the message
// sequencer hands to the write formatter
package host_fifo_pkg;

    // One chunk of the incoming stream
    localparam int CHUNK_BITS = 128;

    // Chunks in a 512-bit cache line, kept a power of two so that the
    // top bit of a chunk count flags a full line
    localparam int CHUNKS_PER_LINE = 4;

    // The ring buffer in host memory holds 2^RING_IDX_BITS lines
    localparam int RING_IDX_BITS = 6;

    typedef logic [CHUNK_BITS-1:0] chunk_t;

    // Index 0 holds the oldest chunk of the line
    typedef logic [CHUNKS_PER_LINE-1:0][CHUNK_BITS-1:0] line_t;

    // Counts 0 to CHUNKS_PER_LINE
    typedef logic [$clog2(CHUNKS_PER_LINE):0] chunk_cnt_t;

    // Wraps around the ring without extra logic
    typedef logic [RING_IDX_BITS-1:0] ring_idx_t;

    // Sized for every chunk the ring can hold
    typedef logic [RING_IDX_BITS+1:0] msg_cnt_t;

    // What the sequencer wants written in the current cycle
    typedef enum logic [1:0]
    {
        phase_idle,
        phase_data,
        phase_header,
        phase_fence
    } emit_phase_t;

    typedef struct packed
    {
        emit_phase_t phase;
        ring_idx_t   header_idx;
        ring_idx_t   data_idx;
        msg_cnt_t    msg_count;
        line_t       header_chunks;
        line_t       data_line;
    } seq_to_fmt_t;

endpackage

// File: host_mem_pkg.sv
// Host memory write port package
// Request format for cache-line writes and fences toward host memory
package host_mem_pkg;

    // Address of a 64-byte line in host memory
    typedef logic [31:0] line_addr_t;

    // A write-through carries a line of data, and a fence orders all
    // earlier writes ahead of any later ones
    typedef enum logic
    {
        write_through,
        write_fence
    } write_kind_t;

    // The request held on the port until the grant
    typedef struct packed
    {
        write_kind_t          kind;
        line_addr_t           addr;
        host_fifo_pkg::line_t data;
    } host_write_t;

endpackage

// File: chunk_line_assembler.sv
// Chunk line assembler
// Shifts arriving chunks into a line-sized buffer and counts them. A flush
// request rotates in padding chunks so a partial line lands in position.
`timescale 1ns/1ps

module chunk_line_assembler
(
    input  logic                      clk,
    input  logic                      resetb,

    // Incoming chunk stream
    input  host_fifo_pkg::chunk_t     tx_data,
    input  logic                      tx_enable,
    output logic                      tx_rdy,

    // Control from the message sequencer
    input  logic                      line_take,
    input  logic                      keep_last,
    input  logic                      force_flush,

    // Line state toward the message sequencer
    output host_fifo_pkg::line_t      line_data,
    output logic                      line_full,
    output logic                      not_empty,
    output host_fifo_pkg::chunk_cnt_t real_count
);

    // Slots taken in the buffer, padding included
    host_fifo_pkg::chunk_cnt_t busy_count;

    // A new chunk or a padding chunk enters the line this cycle
    logic shift_in;

    // ============================================================
    // Buffer status
    // ============================================================

    // The chunk count is a power of two, so its top bit marks a full line
    assign line_full = busy_count[$high(busy_count)];
    assign not_empty = (busy_count != '0);

    // A full line can still accept a chunk in the cycle it is taken.
    // Flushing owns the shift path, so the stream is held off meanwhile
    assign tx_rdy = (!line_full || line_take) && !force_flush;

    // Padding is only rotated in while there is room left
    assign shift_in = tx_enable || (force_flush && !line_full);

    // ============================================================
    // Line shift register
    // ============================================================

    // The newest chunk enters at the top and older ones move toward
    // index 0. A padding chunk is all zeros
    always_ff @(posedge clk)
    begin
        if (shift_in)
        begin
            for (int i = 0; i < host_fifo_pkg::CHUNKS_PER_LINE - 1; i++)
            begin
                line_data[i] <= line_data[i+1];
            end
            line_data[host_fifo_pkg::CHUNKS_PER_LINE-1] <=
                tx_enable ? tx_data : host_fifo_pkg::chunk_t'(0);
        end
    end

    // ============================================================
    // Chunk counters
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            busy_count <= '0;
            real_count <= '0;
        end
        else if (line_take)
        begin
            // What remains is the kept chunk plus any chunk arriving now
            busy_count <= host_fifo_pkg::chunk_cnt_t'(keep_last) +
                          host_fifo_pkg::chunk_cnt_t'(tx_enable);
            real_count <= host_fifo_pkg::chunk_cnt_t'(keep_last) +
                          host_fifo_pkg::chunk_cnt_t'(tx_enable);
        end
        else
        begin
            // Padding takes a slot but is not a real chunk
            busy_count <= busy_count + host_fifo_pkg::chunk_cnt_t'(shift_in);
            real_count <= real_count + host_fifo_pkg::chunk_cnt_t'(tx_enable);
        end
    end

    // The producer honours tx_rdy, which depends on sequencer state
    assert property (@(posedge clk) disable iff (!resetb)
        tx_enable |-> tx_rdy)
    else $error("tx_enable raised while tx_rdy low");

endmodule

// File: message_sequencer.sv
// Message sequencer
// Decides where messages begin and end, tracks the header and data ring
// indices and steps through the data, header and fence writes of a message
`timescale 1ns/1ps

module message_sequencer
#(
    parameter int IDLE_BITS     = 5,
    parameter int MSG_LINE_BITS = 5
)
(
    input  logic                        clk,
    input  logic                        resetb,

    // Line state from the assembler
    input  logic                        line_full,
    input  logic                        not_empty,
    input  host_fifo_pkg::line_t        line_data,
    input  host_fifo_pkg::chunk_cnt_t   real_count,

    // Control back to the assembler
    output logic                        line_take,
    output logic                        keep_last,
    output logic                        force_flush,

    // Write side
    input  logic                        write_grant,
    output host_fifo_pkg::seq_to_fmt_t  seq,
    output host_fifo_pkg::ring_idx_t    next_write_idx
);

    typedef enum logic [2:0]
    {
        st_wait_header,
        st_wait_data,
        st_emit_data,
        st_emit_header,
        st_emit_fence
    } seq_state_t;

    seq_state_t state;

    host_fifo_pkg::ring_idx_t header_idx;
    host_fifo_pkg::ring_idx_t data_idx;
    host_fifo_pkg::msg_cnt_t  msg_count;
    host_fifo_pkg::line_t     header_chunks;
    host_fifo_pkg::line_t     data_line;

    // Close a message after a quiet spell or at the data line limit
    logic [IDLE_BITS-1:0]     idle_cycles;
    logic [MSG_LINE_BITS-1:0] active_lines;
    logic                     idle_hold;
    logic                     full_hold;
    logic                     flush_for_idle;
    logic                     flush_full_msg;

    // ============================================================
    // Flush decisions
    // ============================================================

    assign flush_for_idle = idle_cycles[IDLE_BITS-1] || idle_hold;
    assign flush_full_msg = active_lines[MSG_LINE_BITS-1] || full_hold;

    // Both flags stay up until the message fence goes out
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            idle_hold <= 1'b0;
            full_hold <= 1'b0;
        end
        else
        begin
            idle_hold <= flush_for_idle && (state != st_emit_fence);
            full_hold <= flush_full_msg && (state != st_emit_fence);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            idle_cycles  <= '0;
            active_lines <= '0;
        end
        else
        begin
            // An empty buffer in wait-header means no message has started
            if (state == st_wait_header)
            begin
                idle_cycles <= not_empty ? idle_cycles + IDLE_BITS'(1) : '0;
            end
            else if ((state == st_wait_data) && !line_take)
            begin
                idle_cycles <= idle_cycles + IDLE_BITS'(1);
            end
            else
            begin
                idle_cycles <= '0;
            end

            // Granted data lines of the message now forming
            if (state == st_emit_header)
            begin
                active_lines <= '0;
            end
            else if ((state == st_emit_data) && write_grant)
            begin
                active_lines <= active_lines + MSG_LINE_BITS'(1);
            end
        end
    end

    // ============================================================
    // Assembler control
    // ============================================================

    assign line_take = line_full && !flush_full_msg &&
                       ((state == st_wait_header) || (state == st_wait_data));

    // Chunk 0 of the header carries the length, so a line of four real
    // chunks gives up its newest chunk to the next line
    assign keep_last = (state == st_wait_header) && real_count[$high(real_count)];

    assign force_flush = (state == st_wait_header) && flush_for_idle;

    // ============================================================
    // Message state machine
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state      <= st_wait_header;
            header_idx <= '0;
            data_idx   <= '0;
            msg_count  <= '0;
        end
        else
        begin
            case (state)
                st_wait_header:
                begin
                    // A padded partial line also reports full
                    if (line_take)
                    begin
                        header_chunks <= line_data;
                        msg_count     <= keep_last ?
                            host_fifo_pkg::msg_cnt_t'(host_fifo_pkg::CHUNKS_PER_LINE - 1) :
                            host_fifo_pkg::msg_cnt_t'(real_count);
                        data_idx      <= data_idx + host_fifo_pkg::ring_idx_t'(1);
                        state         <= flush_for_idle ? st_emit_header : st_wait_data;
                    end
                end
                st_wait_data:
                begin
                    // Arriving data wins over the idle timeout
                    if (flush_full_msg)
                    begin
                        state <= st_emit_header;
                    end
                    else if (line_full)
                    begin
                        data_line <= line_data;
                        msg_count <= msg_count +
                            host_fifo_pkg::msg_cnt_t'(host_fifo_pkg::CHUNKS_PER_LINE);
                        state     <= st_emit_data;
                    end
                    else if (flush_for_idle)
                    begin
                        state <= st_emit_header;
                    end
                end
                st_emit_data:
                begin
                    if (write_grant)
                    begin
                        data_idx <= data_idx + host_fifo_pkg::ring_idx_t'(1);
                        state    <= flush_full_msg ? st_emit_header : st_wait_data;
                    end
                end
                st_emit_header:
                begin
                    if (write_grant)
                    begin
                        state <= st_emit_fence;
                    end
                end
                st_emit_fence:
                begin
                    // The next message starts just past the last data line
                    if (write_grant)
                    begin
                        header_idx <= data_idx;
                        state      <= st_wait_header;
                    end
                end
                default:
                begin
                    state <= st_wait_header;
                end
            endcase
        end
    end

    // ============================================================
    // Formatter record
    // ============================================================

    always_comb
    begin
        case (state)
            st_emit_data:   seq.phase = host_fifo_pkg::phase_data;
            st_emit_header: seq.phase = host_fifo_pkg::phase_header;
            st_emit_fence:  seq.phase = host_fifo_pkg::phase_fence;
            default:        seq.phase = host_fifo_pkg::phase_idle;
        endcase
        seq.header_idx    = header_idx;
        seq.data_idx      = data_idx;
        seq.msg_count     = msg_count;
        seq.header_chunks = header_chunks;
        seq.data_line     = data_line;
    end

    assign next_write_idx = header_idx;

    // The host only grants a request that the formatter raised
    assert property (@(posedge clk) disable iff (!resetb)
        write_grant |-> (seq.phase != host_fifo_pkg::phase_idle))
    else $error("write_grant while no write pending");

endmodule

// File: line_write_formatter.sv
// Line write formatter
// Turns the sequencer phase into a host write request and holds writes
// back while the ring has no free line
`timescale 1ns/1ps

module line_write_formatter
(
    input  logic                        clk,
    input  logic                        resetb,
    input  host_fifo_pkg::seq_to_fmt_t  seq,
    input  host_mem_pkg::line_addr_t    ring_base,
    input  host_fifo_pkg::ring_idx_t    oldest_idx,
    input  logic                        write_grant,
    output logic                        write_req,
    output host_mem_pkg::host_write_t   write_cmd
);

    host_fifo_pkg::line_t header_line;
    logic                 ring_space;

    // The ring is full when the next data line would hit the oldest live line
    assign ring_space = (seq.data_idx + host_fifo_pkg::ring_idx_t'(1)) != oldest_idx;

    assign write_req = ring_space && (seq.phase != host_fifo_pkg::phase_idle);

    // Chunk 0 is the message length and the first three payload chunks follow
    always_comb
    begin
        header_line[0] = host_fifo_pkg::chunk_t'(seq.msg_count);
        for (int i = 1; i < host_fifo_pkg::CHUNKS_PER_LINE; i++)
        begin
            header_line[i] = seq.header_chunks[i-1];
        end
    end

    always_comb
    begin
        case (seq.phase)
            host_fifo_pkg::phase_data:
            begin
                write_cmd.kind = host_mem_pkg::write_through;
                write_cmd.addr = ring_base + host_mem_pkg::line_addr_t'(seq.data_idx);
                write_cmd.data = seq.data_line;
            end
            host_fifo_pkg::phase_header:
            begin
                write_cmd.kind = host_mem_pkg::write_through;
                write_cmd.addr = ring_base + host_mem_pkg::line_addr_t'(seq.header_idx);
                write_cmd.data = header_line;
            end
            default:
            begin
                // Fence, which carries no address
                write_cmd.kind = host_mem_pkg::write_fence;
                write_cmd.addr = '0;
                write_cmd.data = header_line;
            end
        endcase
    end

    // A pending request keeps its command until the host takes it
    assert property (@(posedge clk) disable iff (!resetb)
        (write_req && !write_grant) |=> $stable(write_cmd))
    else $error("write_cmd changed before grant");

endmodule

// File: fifo_to_host.sv
// FIFO to host packer
// Packs a 128-bit chunk stream into 512-bit lines and writes them as
// messages into a ring buffer in host memory
`timescale 1ns/1ps

module fifo_to_host
#(
    parameter int IDLE_BITS     = 5,
    parameter int MSG_LINE_BITS = 5
)
(
    input  logic                       clk,
    input  logic                       resetb,

    // Chunk stream
    input  host_fifo_pkg::chunk_t      tx_data,
    input  logic                       tx_enable,
    output logic                       tx_rdy,

    // Ring placement and host progress
    input  host_mem_pkg::line_addr_t   ring_base,
    input  host_fifo_pkg::ring_idx_t   oldest_idx,
    output host_fifo_pkg::ring_idx_t   next_write_idx,

    // Host write port
    output logic                       write_req,
    output host_mem_pkg::host_write_t  write_cmd,
    input  logic                       write_grant
);

    // Assembler to sequencer
    host_fifo_pkg::line_t       line_data;
    host_fifo_pkg::chunk_cnt_t  real_count;
    logic                       line_full;
    logic                       not_empty;

    // Sequencer to assembler
    logic                       line_take;
    logic                       keep_last;
    logic                       force_flush;

    // Sequencer to formatter
    host_fifo_pkg::seq_to_fmt_t seq;

    chunk_line_assembler u_assembler
    (
        .clk         (clk),
        .resetb      (resetb),
        .tx_data     (tx_data),
        .tx_enable   (tx_enable),
        .tx_rdy      (tx_rdy),
        .line_take   (line_take),
        .keep_last   (keep_last),
        .force_flush (force_flush),
        .line_data   (line_data),
        .line_full   (line_full),
        .not_empty   (not_empty),
        .real_count  (real_count)
    );

    message_sequencer
    #(
        .IDLE_BITS     (IDLE_BITS),
        .MSG_LINE_BITS (MSG_LINE_BITS)
    )
    u_sequencer
    (
        .clk            (clk),
        .resetb         (resetb),
        .line_full      (line_full),
        .not_empty      (not_empty),
        .line_data      (line_data),
        .real_count     (real_count),
        .line_take      (line_take),
        .keep_last      (keep_last),
        .force_flush    (force_flush),
        .write_grant    (write_grant),
        .seq            (seq),
        .next_write_idx (next_write_idx)
    );

    line_write_formatter u_formatter
    (
        .clk         (clk),
        .resetb      (resetb),
        .seq         (seq),
        .ring_base   (ring_base),
        .oldest_idx  (oldest_idx),
        .write_grant (write_grant),
        .write_req   (write_req),
        .write_cmd   (write_cmd)
    );

endmodule

// File: tb_fifo_to_host.sv
// Testbench for the FIFO to host packer
// Streams chunk messages from a table, grants host writes with random stalls,
// rebuilds messages from a host memory model and compares them with the stream
`timescale 1ns/1ps

module tb_fifo_to_host;

    localparam int NUM_TESTS   = 5;
    localparam int RING_LINES  = 1 << host_fifo_pkg::RING_IDX_BITS;
    localparam int STALL_LIMIT = 400;
    localparam int WAIT_LIMIT  = 3000;
    localparam int DRAIN_LIMIT = 6000;

    // Each row is one test and adds the expected message count and the first
    // header count, where 0 skips that check
    typedef struct packed
    {
        int len;
        int gap;
        int stall_pct;
        int freeze;
        int exp_msgs;
        int exp_first;
    } test_row_t;

    logic                       clk;
    logic                       resetb;
    host_fifo_pkg::chunk_t      tx_data;
    logic                       tx_enable;
    logic                       tx_rdy;
    host_mem_pkg::line_addr_t   ring_base;
    host_fifo_pkg::ring_idx_t   oldest_idx;
    host_fifo_pkg::ring_idx_t   next_write_idx;
    logic                       write_req;
    host_mem_pkg::host_write_t  write_cmd;
    logic                       write_grant;

    // ============================================================
    // Host memory model and scoreboard state
    // ============================================================

    test_row_t                  rows [NUM_TESTS];
    host_fifo_pkg::line_t       mem [host_mem_pkg::line_addr_t];
    host_fifo_pkg::chunk_t      sent [$];
    host_fifo_pkg::chunk_t      recv [$];
    host_fifo_pkg::ring_idx_t   rd_idx;
    host_fifo_pkg::ring_idx_t   frozen_val;
    host_mem_pkg::line_addr_t   last_addr;
    bit                         frozen;
    bit                         stall_seen;
    bit                         idx_check_pending;
    int                         stall_pct;
    int                         msgs_in_test;
    int                         first_count;
    int                         errors;
    int                         checks;
    int                         tests_failed;

    fifo_to_host #(.IDLE_BITS(5), .MSG_LINE_BITS(3)) DUT
    (
        .clk            (clk),
        .resetb         (resetb),
        .tx_data        (tx_data),
        .tx_enable      (tx_enable),
        .tx_rdy         (tx_rdy),
        .ring_base      (ring_base),
        .oldest_idx     (oldest_idx),
        .next_write_idx (next_write_idx),
        .write_req      (write_req),
        .write_cmd      (write_cmd),
        .write_grant    (write_grant)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("ERROR t=%0t: %s", $time, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Walks one fenced message from its header line and collects its payload
    task automatic read_message();
        host_fifo_pkg::line_t     hdr;
        host_fifo_pkg::line_t     dl;
        host_mem_pkg::line_addr_t hdr_addr;
        int                       n;
        int                       lines;
        hdr_addr = ring_base + host_mem_pkg::line_addr_t'(rd_idx);
        check_value("header_before_fence", last_addr, hdr_addr);
        if (!mem.exists(hdr_addr))
        begin
            abort_run("fence arrived with no header line in memory");
        end
        hdr = mem[hdr_addr];
        n = int'(hdr[0][31:0]);
        lines = (n > 3) ? (n - 3) / 4 : 0;
        // Past the header, the count grows a whole line at a time
        if (n > 3)
        begin
            check_value("count_line_align", (n - 3) % 4, 0);
        end
        check_value("data_lines_max_4", lines <= 4, 1);
        check_value("count_nonzero", n > 0, 1);
        if (msgs_in_test == 0)
        begin
            first_count = n;
        end
        msgs_in_test++;
        for (int i = 1; i <= 3 && i <= n; i++)
        begin
            recv.push_back(hdr[i]);
        end
        for (int l = 0; l < lines; l++)
        begin
            dl = mem[ring_base + host_mem_pkg::line_addr_t'(
                     host_fifo_pkg::ring_idx_t'(rd_idx + 1 + l))];
            for (int j = 0; j < host_fifo_pkg::CHUNKS_PER_LINE; j++)
            begin
                recv.push_back(dl[j]);
            end
        end
        rd_idx = host_fifo_pkg::ring_idx_t'(rd_idx + 1 + lines);
        idx_check_pending = 1'b1;
    endtask

    task automatic store_write(input host_mem_pkg::host_write_t cmd);
        host_fifo_pkg::ring_idx_t idx;
        if (cmd.kind == host_mem_pkg::write_through)
        begin
            idx = host_fifo_pkg::ring_idx_t'(cmd.addr - ring_base);
            check_value("write_addr_in_ring", (cmd.addr - ring_base) < RING_LINES, 1);
            // The line just below the oldest live line stays untouched
            if (frozen)
            begin
                check_value("ring_guard", idx == host_fifo_pkg::ring_idx_t'(frozen_val - 1), 0);
            end
            mem[cmd.addr] = cmd.data;
            last_addr = cmd.addr;
        end
        else
        begin
            check_value("fence_addr", cmd.addr, 0);
            read_message();
        end
    endtask

    // Host side. Updates oldest_idx, drives the grant, then samples at the
    // falling edge where the request and command are settled
    initial
    begin : host_model
        host_mem_pkg::host_write_t cmd;
        forever
        begin
            @(posedge clk);
            #1;
            if (!frozen)
            begin
                oldest_idx = rd_idx;
            end
            if (idx_check_pending)
            begin
                check_value("next_write_idx", next_write_idx, rd_idx);
                idx_check_pending = 1'b0;
            end
            #1;
            write_grant = resetb && (write_req === 1'b1) &&
                          (int'($urandom % 100) >= stall_pct);
            @(negedge clk);
            if ((write_req === 1'b1) && write_grant)
            begin
                cmd = write_cmd;
                store_write(cmd);
            end
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================

    task automatic release_ring();
        stall_seen = 1'b1;
        frozen = 1'b0;
    endtask

    task automatic send_chunk(input host_fifo_pkg::chunk_t v);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        while (!tx_rdy)
        begin
            tx_enable = 1'b0;
            // A long stall with a frozen oldest index means the ring is full
            if (frozen && (waited >= STALL_LIMIT))
            begin
                release_ring();
            end
            if (waited >= WAIT_LIMIT)
            begin
                abort_run("tx_rdy stayed low with no progress");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        tx_enable = 1'b1;
        tx_data = v;
        sent.push_back(v);
    endtask

    task automatic run_test(input int t);
        host_fifo_pkg::chunk_t v;
        int                    base_idx;
        int                    waited;
        int                    err_before;
        err_before = errors;
        base_idx = sent.size();
        msgs_in_test = 0;
        first_count = 0;
        stall_pct = rows[t].stall_pct;
        if (rows[t].freeze != 0)
        begin
            frozen_val = oldest_idx;
            frozen = 1'b1;
            stall_seen = 1'b0;
        end
        for (int i = 0; i < rows[t].len; i++)
        begin
            v = {32'(t), 32'(i), $urandom, $urandom};
            send_chunk(v);
        end
        @(posedge clk);
        #1;
        tx_enable = 1'b0;
        waited = 0;
        while (recv.size() < sent.size())
        begin
            @(posedge clk);
            waited++;
            if (waited >= DRAIN_LIMIT)
            begin
                abort_run("sent chunks never came back as messages");
            end
        end
        repeat (rows[t].gap) @(posedge clk);
        check_value("received_size", recv.size(), sent.size());
        for (int k = base_idx; k < sent.size() && k < recv.size(); k++)
        begin
            check_value("payload_chunk", recv[k], sent[k]);
        end
        if (rows[t].exp_msgs != 0)
        begin
            check_value("message_count", msgs_in_test, rows[t].exp_msgs);
        end
        if (rows[t].exp_first != 0)
        begin
            check_value("first_header_count", first_count, rows[t].exp_first);
        end
        if (rows[t].freeze != 0)
        begin
            check_value("ring_full_stall", stall_seen, 1);
            frozen = 1'b0;
        end
        if (errors != err_before)
        begin
            tests_failed++;
        end
        $display("test %0d len=%0d stall=%0d%% freeze=%0d messages=%0d : %s", t,
                 rows[t].len, rows[t].stall_pct, rows[t].freeze, msgs_in_test,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial
    begin : main
        void'($urandom(10));
        resetb = 1'b0;
        tx_enable = 1'b0;
        tx_data = '0;
        ring_base = 32'h0000_4000;
        oldest_idx = '0;
        write_grant = 1'b0;
        frozen = 1'b0;
        frozen_val = '0;
        stall_seen = 1'b0;
        idx_check_pending = 1'b0;
        rd_idx = '0;
        last_addr = '0;
        stall_pct = 0;
        errors = 0;
        checks = 0;
        tests_failed = 0;

        // len, gap, stall percent, freeze, messages, first count
        rows[0] = '{2, 40, 0, 0, 1, 2};
        rows[1] = '{11, 40, 0, 0, 1, 11};
        rows[2] = '{90, 40, 0, 0, 0, 19};
        rows[3] = '{60, 40, 50, 0, 0, 0};
        rows[4] = '{320, 60, 20, 1, 0, 0};

        repeat (4) @(posedge clk);
        #1;
        resetb = 1'b1;
        check_value("write_req_after_reset", write_req, 0);
        check_value("tx_rdy_after_reset", tx_rdy, 1);

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_test(t);
        end

        $display("tests=%0d failed=%0d checks=%0d errors=%0d",
                 NUM_TESTS, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
host_fifo_pkg.sv
host_mem_pkg.sv
chunk_line_assembler.sv
message_sequencer.sv
line_write_formatter.sv
fifo_to_host.sv
tb_fifo_to_host.sv

// File: run_sim.sh
#!/bin/sh
# Builds the packer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fifo_to_host \
    -f filelist.f -o sim_fifo_to_host > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_fifo_to_host > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
